//--- rtl/eth_stats_pkg.sv
// PORT_COUNT must equal 2**$bits(port_idx_t) and UART_CLKS_PER_BIT is a simulation rate only
package eth_stats_pkg;

    // Port and counter layout
    localparam int PORT_COUNT     = 4;
    localparam int STATS_PER_PORT = 2;
    localparam int STAT_COUNT     = PORT_COUNT * STATS_PER_PORT;
    localparam int STAT_ID_W      = 3;
    localparam int STAT_COUNT_W   = 32;
    localparam int STAT_INC_W     = 16;

    // Jumbo limit beyond which frames count as bad
    localparam int MAX_FRAME_LEN = 9218;

    // Far above 115200 baud at 125 MHz
    localparam int UART_CLKS_PER_BIT = 16;

    localparam logic [7:0] STAT_ERR_BYTE = 8'hEE;

    typedef logic [7:0]                            byte_t;
    typedef logic [STAT_ID_W-1:0]                  stat_id_t;
    typedef logic [STAT_INC_W-1:0]                 stat_inc_t;
    typedef logic [STAT_COUNT_W-1:0]               stat_count_t;
    typedef logic [1:0]                            port_idx_t;
    typedef logic [$clog2(UART_CLKS_PER_BIT)-1:0]  baud_cnt_t;

    typedef struct packed {
        logic  dv;
        logic  er;
        byte_t data;
    } gmii_t;

    typedef struct packed {
        stat_id_t  id;
        stat_inc_t inc;
    } stat_event_t;

    typedef enum logic [1:0] {
        RD_IDLE,
        RD_FETCH,
        RD_SEND,
        RD_WAIT
    } reader_state_t;

endpackage

//--- rtl/gmii_port_monitor.sv
// Counts dv bytes without preamble or FCS checks and holds only one pending event
module gmii_port_monitor import eth_stats_pkg::*; (
    input  logic        clk_125mhz,
    input  logic        reset,
    input  port_idx_t   port,
    input  gmii_t       rx,
    output gmii_t       tx,
    output stat_event_t ev,
    output logic        ev_valid,
    input  logic        ev_ready
);

    stat_inc_t frame_len;
    logic      frame_bad;
    logic      frame_end;

    // Loopback register doubles as the previous-cycle dv
    assign frame_end = tx.dv && !rx.dv;

    always_ff @(posedge clk_125mhz) begin
        tx <= rx;
        if (reset) begin
            tx.dv <= 1'b0;
            tx.er <= 1'b0;
        end
    end

    // Length saturates at the limit, one byte more marks the frame bad
    always_ff @(posedge clk_125mhz) begin
        if (rx.dv) begin
            if (!tx.dv) begin
                frame_len <= stat_inc_t'(1);
                frame_bad <= rx.er;
            end else begin
                if (frame_len < stat_inc_t'(MAX_FRAME_LEN)) begin
                    frame_len <= frame_len + 1'b1;
                end
                frame_bad <= frame_bad | rx.er | (frame_len >= stat_inc_t'(MAX_FRAME_LEN));
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            ev_valid <= 1'b0;
        end else if (frame_end) begin
            ev_valid <= 1'b1;
        end else if (ev_ready) begin
            ev_valid <= 1'b0;
        end
    end

    // Good frames add bytes, bad frames add one to the odd counter
    always_ff @(posedge clk_125mhz) begin
        if (frame_end) begin
            if (frame_bad) begin
                ev.id  <= stat_id_t'(port * STATS_PER_PORT + 1);
                ev.inc <= stat_inc_t'(1);
            end else begin
                ev.id  <= stat_id_t'(port * STATS_PER_PORT);
                ev.inc <= frame_len;
            end
        end
    end

    // Arbiter must drain the holding register before the next frame ends
    no_event_lost_a: assert property (
        @(posedge clk_125mhz) disable iff (reset)
        frame_end |-> (!ev_valid || ev_ready)
    );

endmodule

//--- rtl/stat_arb_mux.sv
// Round robin over a power-of-two PORT_COUNT and assumes the downstream sink never stalls
module stat_arb_mux import eth_stats_pkg::*; (
    input  logic                  clk_125mhz,
    input  logic                  reset,
    input  stat_event_t           in_ev [PORT_COUNT],
    input  logic [PORT_COUNT-1:0] in_valid,
    output logic [PORT_COUNT-1:0] in_ready,
    output stat_event_t           out_ev,
    output logic                  out_valid
);

    port_idx_t last_q;
    port_idx_t win;
    logic      win_valid;

    // Scan from the farthest offset so the nearest requester after last_q wins
    always_comb begin
        port_idx_t cand;
        win       = last_q;
        win_valid = 1'b0;
        for (int i = PORT_COUNT; i >= 1; i--) begin
            cand = port_idx_t'(int'(last_q) + i);
            if (in_valid[cand]) begin
                win       = cand;
                win_valid = 1'b1;
            end
        end
    end

    always_comb begin
        in_ready = '0;
        if (win_valid) begin
            in_ready[win] = 1'b1;
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            out_valid <= 1'b0;
            last_q    <= port_idx_t'(PORT_COUNT - 1);
        end else begin
            out_valid <= win_valid;
            if (win_valid) begin
                last_q <= win;
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (win_valid) begin
            out_ev <= in_ev[win];
        end
    end

    // At most one grant and only to a port that is requesting
    grant_onehot_a: assert property (
        @(posedge clk_125mhz) disable iff (reset)
        $onehot0(in_ready) && ((in_ready & ~in_valid) == '0)
    );

endmodule

//--- rtl/stat_counters.sv
// Counters wrap at STAT_COUNT_W bits and a read shows the value sampled one cycle after rd_id
module stat_counters import eth_stats_pkg::*; (
    input  logic        clk_125mhz,
    input  logic        reset,
    input  stat_event_t inc_ev,
    input  logic        inc_valid,
    input  stat_id_t    rd_id,
    output stat_count_t rd_data
);

    stat_count_t cnt [STAT_COUNT];

    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            for (int i = 0; i < STAT_COUNT; i++) begin
                cnt[i] <= '0;
            end
        end else if (inc_valid) begin
            cnt[inc_ev.id] <= cnt[inc_ev.id] + stat_count_t'(inc_ev.inc);
        end
    end

    // Same-cycle increment and read returns the old value
    always_ff @(posedge clk_125mhz) begin
        rd_data <= cnt[rd_id];
    end

    // Monitors must only name counters that exist
    inc_id_range_a: assert property (
        @(posedge clk_125mhz) disable iff (reset)
        inc_valid |-> (int'(inc_ev.id) < STAT_COUNT)
    );

endmodule

//--- rtl/uart_rx.sv
// 8N1 only with no parity and a frame whose stop bit is low is dropped without notice
module uart_rx import eth_stats_pkg::*; (
    input  logic  clk_125mhz,
    input  logic  reset,
    input  logic  rxd,
    output byte_t rx_data,
    output logic  rx_valid
);

    logic       rxd_meta;
    logic       rxd_sync;
    logic       active;
    logic       sample;
    baud_cnt_t  baud_cnt;
    logic [3:0] bit_idx;
    byte_t      shreg;

    // Two-stage synchronizer, idles high
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
        end else begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
        end
    end

    assign sample = active && (baud_cnt == '0);

    // Bit 0 is the start bit, 1 to 8 data, 9 the stop bit
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            active   <= 1'b0;
            rx_valid <= 1'b0;
            baud_cnt <= '0;
            bit_idx  <= '0;
        end else begin
            rx_valid <= 1'b0;
            if (!active) begin
                if (!rxd_sync) begin
                    active   <= 1'b1;
                    baud_cnt <= baud_cnt_t'(UART_CLKS_PER_BIT / 2 - 1);
                    bit_idx  <= '0;
                end
            end else if (!sample) begin
                baud_cnt <= baud_cnt - 1'b1;
            end else begin
                baud_cnt <= baud_cnt_t'(UART_CLKS_PER_BIT - 1);
                bit_idx  <= bit_idx + 1'b1;
                if (bit_idx == 4'd0 && rxd_sync) begin
                    // Glitch, not a start bit
                    active <= 1'b0;
                end else if (bit_idx == 4'd9) begin
                    active   <= 1'b0;
                    rx_valid <= rxd_sync;
                end
            end
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (sample && bit_idx != 4'd0 && bit_idx != 4'd9) begin
            shreg <= {rxd_sync, shreg[7:1]};
        end
        if (sample && bit_idx == 4'd9) begin
            rx_data <= shreg;
        end
    end

endmodule

//--- rtl/uart_tx.sv
// 8N1 only and the caller must hold tx_start low while tx_busy is high
module uart_tx import eth_stats_pkg::*; (
    input  logic  clk_125mhz,
    input  logic  reset,
    input  byte_t tx_data,
    input  logic  tx_start,
    output logic  txd,
    output logic  tx_busy
);

    logic [8:0] shreg;
    baud_cnt_t  baud_cnt;
    logic [3:0] bits_left;

    // Start bit goes out at once, then eight data bits and the stop bit
    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            txd       <= 1'b1;
            tx_busy   <= 1'b0;
            baud_cnt  <= '0;
            bits_left <= '0;
        end else if (!tx_busy) begin
            if (tx_start) begin
                txd       <= 1'b0;
                tx_busy   <= 1'b1;
                baud_cnt  <= baud_cnt_t'(UART_CLKS_PER_BIT - 1);
                bits_left <= 4'd9;
            end
        end else if (baud_cnt != '0) begin
            baud_cnt <= baud_cnt - 1'b1;
        end else if (bits_left == '0) begin
            tx_busy <= 1'b0;
        end else begin
            txd       <= shreg[0];
            bits_left <= bits_left - 1'b1;
            baud_cnt  <= baud_cnt_t'(UART_CLKS_PER_BIT - 1);
        end
    end

    // Stop bit rides above the data byte
    always_ff @(posedge clk_125mhz) begin
        if (!tx_busy && tx_start) begin
            shreg <= {1'b1, tx_data};
        end else if (tx_busy && baud_cnt == '0 && bits_left != '0) begin
            shreg <= {1'b1, shreg[8:1]};
        end
    end

    start_while_busy_a: assert property (
        @(posedge clk_125mhz) disable iff (reset)
        tx_start |-> !tx_busy
    );

endmodule

//--- rtl/stat_uart_reader.sv
// One command byte per reply and bytes that arrive while a reply is in progress are discarded
module stat_uart_reader import eth_stats_pkg::*; (
    input  logic        clk_125mhz,
    input  logic        reset,
    input  byte_t       rx_data,
    input  logic        rx_valid,
    output byte_t       tx_data,
    output logic        tx_start,
    input  logic        tx_busy,
    output stat_id_t    rd_id,
    input  stat_count_t rd_data
);

    reader_state_t state;
    stat_count_t   reply_q;
    logic [2:0]    bytes_left;

    // rx_data holds the command byte, so the counter read starts with rx_valid
    assign rd_id = rx_data[STAT_ID_W-1:0];

    // Reply goes out MSB first
    assign tx_data  = reply_q[STAT_COUNT_W-1 -: 8];
    assign tx_start = (state == RD_SEND) && !tx_busy;

    always_ff @(posedge clk_125mhz) begin
        if (reset) begin
            state      <= RD_IDLE;
            bytes_left <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (rx_valid) begin
                        if (rx_data < STAT_COUNT) begin
                            state <= RD_FETCH;
                        end else begin
                            bytes_left <= 3'd1;
                            state      <= RD_SEND;
                        end
                    end
                end
                RD_FETCH: begin
                    bytes_left <= 3'(STAT_COUNT_W / 8);
                    state      <= RD_SEND;
                end
                RD_SEND: begin
                    if (tx_start) begin
                        bytes_left <= bytes_left - 1'b1;
                        state      <= RD_WAIT;
                    end
                end
                RD_WAIT: begin
                    // tx_busy is already high on the first cycle here
                    if (!tx_busy) begin
                        state <= (bytes_left == '0) ? RD_IDLE : RD_SEND;
                    end
                end
                default: begin
                    state <= RD_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk_125mhz) begin
        if (state == RD_IDLE && rx_valid) begin
            reply_q <= stat_count_t'(STAT_ERR_BYTE) << (STAT_COUNT_W - 8);
        end else if (state == RD_FETCH) begin
            reply_q <= rd_data;
        end else if (tx_start) begin
            reply_q <= reply_q << 8;
        end
    end

endmodule

//--- rtl/fpga_core.sv
// Single clock domain with GMII loopback and byte counts taken only from dv without FCS checks
module fpga_core import eth_stats_pkg::*; (
    input  wire logic  clk_125mhz,
    input  wire logic  reset,

    input  wire byte_t sw,
    output wire byte_t led,

    input  wire logic  uart_rxd,
    output wire logic  uart_txd,

    input  wire gmii_t gmii_rx [PORT_COUNT],
    output wire gmii_t gmii_tx [PORT_COUNT]
);

    stat_event_t           port_ev [PORT_COUNT];
    logic [PORT_COUNT-1:0] port_ev_valid;
    logic [PORT_COUNT-1:0] port_ev_ready;
    stat_event_t           stat_ev;
    logic                  stat_valid;
    stat_id_t              rd_id;
    stat_count_t           rd_data;
    byte_t                 rx_data;
    logic                  rx_valid;
    byte_t                 tx_data;
    logic                  tx_start;
    logic                  tx_busy;

    assign led = sw;

    for (genvar p = 0; p < PORT_COUNT; p++) begin : port_ch
        gmii_port_monitor port_mon_inst (
            .clk_125mhz (clk_125mhz),
            .reset      (reset),
            .port       (port_idx_t'(p)),
            .rx         (gmii_rx[p]),
            .tx         (gmii_tx[p]),
            .ev         (port_ev[p]),
            .ev_valid   (port_ev_valid[p]),
            .ev_ready   (port_ev_ready[p])
        );
    end

    stat_arb_mux stat_mux_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .in_ev      (port_ev),
        .in_valid   (port_ev_valid),
        .in_ready   (port_ev_ready),
        .out_ev     (stat_ev),
        .out_valid  (stat_valid)
    );

    stat_counters stat_cnt_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .inc_ev     (stat_ev),
        .inc_valid  (stat_valid),
        .rd_id      (rd_id),
        .rd_data    (rd_data)
    );

    uart_rx uart_rx_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .rxd        (uart_rxd),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid)
    );

    uart_tx uart_tx_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .txd        (uart_txd),
        .tx_busy    (tx_busy)
    );

    stat_uart_reader reader_inst (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .rx_data    (rx_data),
        .rx_valid   (rx_valid),
        .tx_data    (tx_data),
        .tx_start   (tx_start),
        .tx_busy    (tx_busy),
        .rd_id      (rd_id),
        .rd_data    (rd_data)
    );

endmodule

//--- test/tb_fpga_core.sv
// Frame rounds of PORT_COUNT+1 cycles or more let the arbiter drain every event in time
module tb_fpga_core import eth_stats_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int GOOD_ROUNDS  = 40;
    localparam int BAD_ROUNDS   = 12;
    localparam int MAX_LEN      = 64;
    localparam int ROUND_CYCLES = MAX_LEN + 1;
    localparam int QUERIES      = 3 * STAT_COUNT + (256 - STAT_COUNT);
    localparam int FRAME_NS     = (GOOD_ROUNDS + BAD_ROUNDS) * ROUND_CYCLES * 4;
    localparam int QUERY_NS     = QUERIES * 5 * 10 * UART_CLKS_PER_BIT * 4;
    localparam int TEST_NS      = FRAME_NS + QUERY_NS;

    logic  clk_125mhz;
    logic  reset;
    byte_t sw;
    byte_t led;
    logic  uart_rxd;
    logic  uart_txd;
    gmii_t gmii_rx [PORT_COUNT];
    gmii_t gmii_tx [PORT_COUNT];
    gmii_t rx_prev [PORT_COUNT];
    logic  loop_check_en;

    // One entry per frame sent
    int   sent_port [$];
    int   sent_len  [$];
    logic sent_bad  [$];

    int round_len [PORT_COUNT];
    int err_pos   [PORT_COUNT];

    fpga_core UUT (
        .clk_125mhz (clk_125mhz),
        .reset      (reset),
        .sw         (sw),
        .led        (led),
        .uart_rxd   (uart_rxd),
        .uart_txd   (uart_txd),
        .gmii_rx    (gmii_rx),
        .gmii_tx    (gmii_tx)
    );

    always #2 clk_125mhz = ~clk_125mhz;

    // Good frames add their length to the even counter and bad ones add one to the odd
    function automatic stat_count_t expected_count(input int idx);
        stat_count_t sum;
        sum = '0;
        for (int i = 0; i < sent_port.size(); i++) begin
            if (!sent_bad[i] && idx == sent_port[i] * 2) begin
                sum = sum + stat_count_t'(sent_len[i]);
            end else if (sent_bad[i] && idx == sent_port[i] * 2 + 1) begin
                sum = sum + stat_count_t'(1);
            end
        end
        return sum;
    endfunction

    task automatic stop_run(input string line);
        $display("%s", line);
        $display("ERRORS FOUND");
        $fatal(1, "run stopped at the first failure");
    endtask

    // All ports start together and each ends after its own round_len
    task automatic send_round(input logic [PORT_COUNT-1:0] bad_mask);
        int cycles;
        cycles = PORT_COUNT + 1;
        for (int p = 0; p < PORT_COUNT; p++) begin
            if (round_len[p] + 1 > cycles) begin
                cycles = round_len[p] + 1;
            end
            err_pos[p] = int'($urandom_range(round_len[p] - 1, 0));
            sent_port.push_back(p);
            sent_len.push_back(round_len[p]);
            sent_bad.push_back(bad_mask[p]);
        end
        @(posedge clk_125mhz);
        #1;
        for (int c = 0; c < cycles; c++) begin
            for (int p = 0; p < PORT_COUNT; p++) begin
                gmii_rx[p].dv   = (c < round_len[p]);
                gmii_rx[p].er   = bad_mask[p] && (c == err_pos[p]);
                gmii_rx[p].data = byte_t'($urandom);
            end
            sw = byte_t'($urandom);
            @(posedge clk_125mhz);
            #1;
        end
    endtask

    task automatic send_uart_byte(input byte_t b);
        logic [8:0] bits;
        bits = {b, 1'b0};
        @(posedge clk_125mhz);
        #1;
        for (int i = 0; i < 9; i++) begin
            uart_rxd = bits[i];
            repeat (UART_CLKS_PER_BIT) @(posedge clk_125mhz);
            #1;
        end
        // Stop bit stays on the line while the reply starts
        uart_rxd = 1'b1;
    endtask

    task automatic recv_uart_byte(output byte_t b);
        int wait_cycles;
        wait_cycles = 0;
        b = '0;
        @(negedge clk_125mhz);
        while (uart_txd) begin
            wait_cycles++;
            assert (wait_cycles <= 4 * 10 * UART_CLKS_PER_BIT) else
                stop_run("The DUT never started the expected UART reply byte");
            @(negedge clk_125mhz);
        end
        repeat (UART_CLKS_PER_BIT / 2) @(negedge clk_125mhz);
        assert (uart_txd == 1'b0) else
            stop_run($sformatf("ERR %0t: UART start bit too short", $time));
        for (int i = 0; i < 8; i++) begin
            repeat (UART_CLKS_PER_BIT) @(negedge clk_125mhz);
            b[i] = uart_txd;
        end
        repeat (UART_CLKS_PER_BIT) @(negedge clk_125mhz);
        assert (uart_txd == 1'b1) else
            stop_run($sformatf("ERR %0t: UART stop bit is low", $time));
    endtask

    task automatic query_counter(input byte_t cmd, input int nbytes, output stat_count_t value);
        byte_t b;
        value = '0;
        send_uart_byte(cmd);
        for (int i = 0; i < nbytes; i++) begin
            recv_uart_byte(b);
            value = {value[STAT_COUNT_W-9:0], b};
        end
        // No further byte may follow
        repeat (3 * UART_CLKS_PER_BIT) begin
            @(negedge clk_125mhz);
            assert (uart_txd == 1'b1) else
                stop_run($sformatf("ERR %0t: extra reply byte after command %0d", $time, cmd));
        end
    endtask

    task automatic check_counters(input string phase);
        stat_count_t got;
        stat_count_t exp;
        for (int idx = 0; idx < STAT_COUNT; idx++) begin
            query_counter(byte_t'(idx), STAT_COUNT_W / 8, got);
            exp = expected_count(idx);
            assert (got == exp) else
                stop_run($sformatf("ERR %0t: %s, counter %0d read %0d, expected %0d",
                                   $time, phase, idx, got, exp));
        end
    endtask

    always @(posedge clk_125mhz) begin
        rx_prev       <= gmii_rx;
        loop_check_en <= !reset;
    end

    // Loopback and LEDs checked mid-cycle
    always @(negedge clk_125mhz) begin
        if (loop_check_en) begin
            for (int p = 0; p < PORT_COUNT; p++) begin
                assert (gmii_tx[p] == rx_prev[p]) else
                    stop_run($sformatf("ERR %0t: port %0d tx %h, expected %h",
                                       $time, p, gmii_tx[p], rx_prev[p]));
            end
        end
        assert (led == sw) else
            stop_run($sformatf("ERR %0t: led %h, expected %h", $time, led, sw));
    end

    initial begin
        #(2 * TEST_NS);
        $display("Timeout: the test ran longer than twice its expected length");
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    initial begin
        stat_count_t           got;
        logic [PORT_COUNT-1:0] mask;
        int                    common_len;
        void'($urandom(83));
        clk_125mhz = 1'b0;
        reset      = 1'b1;
        sw         = '0;
        uart_rxd   = 1'b1;
        for (int p = 0; p < PORT_COUNT; p++) begin
            gmii_rx[p] = '0;
        end
        repeat (8) @(posedge clk_125mhz);
        #1;
        reset = 1'b0;

        check_counters("after reset");

        for (int r = 0; r < GOOD_ROUNDS; r++) begin
            for (int p = 0; p < PORT_COUNT; p++) begin
                round_len[p] = int'($urandom_range(MAX_LEN, 1));
            end
            send_round('0);
        end
        repeat (50) @(posedge clk_125mhz);
        check_counters("good frames");

        // Equal lengths so all ports end on the same cycle
        for (int r = 0; r < BAD_ROUNDS; r++) begin
            common_len = int'($urandom_range(MAX_LEN, 1));
            mask       = (r % 3 == 0) ? '1 : PORT_COUNT'($urandom);
            for (int p = 0; p < PORT_COUNT; p++) begin
                round_len[p] = common_len;
            end
            send_round(mask);
        end
        repeat (50) @(posedge clk_125mhz);
        check_counters("bad frames");

        for (int idx = STAT_COUNT; idx < 256; idx++) begin
            query_counter(byte_t'(idx), 1, got);
            assert (got == stat_count_t'(8'hEE)) else
                stop_run($sformatf("ERR %0t: index %0d replied %h, expected ee",
                                   $time, idx, got));
        end

        $display("NO ERRORS");
        $finish;
    end

endmodule

//--- flist.f
rtl/eth_stats_pkg.sv
rtl/gmii_port_monitor.sv
rtl/stat_arb_mux.sv
rtl/stat_counters.sv
rtl/uart_rx.sv
rtl/uart_tx.sv
rtl/stat_uart_reader.sv
rtl/fpga_core.sv
test/tb_fpga_core.sv

//--- run_sim.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_fpga_core -f flist.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/Vtb_fpga_core)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qx "NO ERRORS"; then
    exit 0
fi
exit 1
